// ==== design/mem_pkg.sv ====
package mem_pkg;

    localparam int word_width        = 32;                  // data and address width
    localparam int ram_addr_bits     = 14;                  // 16K words, 64 KB
    localparam int byte_offset_bits  = 2;                   // byte lane inside a word
    localparam int ram_limit_bits    = 16;                  // bits 31..16, zero for RAM
    localparam int io_marker_bits    = 22;                  // bits 31..10 mark the IO window
    localparam int io_type_bit       = 4;                   // 0 keypad, 1 VGA

    localparam logic [io_marker_bits-1:0] io_marker = {io_marker_bits{1'b1}}; // 0xFFFFFC00 up

    // spare bits between the marker and the device-type bit
    localparam int io_unused_bits    = word_width - io_marker_bits - io_type_bit - 1;

    // one address word, two ways of reading it
    typedef union packed {
        struct packed {
            logic [ram_limit_bits-1:0]   upper;             // must be zero for a RAM hit
            logic [ram_addr_bits-1:0]    word_index;        // RAM word address
            logic [byte_offset_bits-1:0] byte_offset;       // ignored, word access only
        } ram;
        struct packed {
            logic [io_marker_bits-1:0]   marker;            // all ones inside the IO window
            logic [io_unused_bits-1:0]   unused;            // not decoded
            logic                        dev_type;          // device select bit
            logic [io_type_bit-1:0]      offset;            // byte offset inside a device
        } io;
    } mem_addr_t;

endpackage

// ==== design/uart_loader.sv ====
`timescale 1ns/1ps

module uart_loader (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load_mode,       // loader owns the RAM
    input  logic                               uart_byte_valid, // one framed byte this cycle
    input  logic [7:0]                         uart_byte,
    output logic                               load_write,      // RAM write strobe
    output logic [mem_pkg::ram_addr_bits-1:0]  load_word_addr,
    output logic [mem_pkg::word_width-1:0]     load_word,
    output logic [mem_pkg::ram_addr_bits:0]    load_count       // words written so far
);
    import mem_pkg::*;

    logic                     load_mode_q;                  // for rise detect
    logic [1:0]               byte_count;                   // bytes held in shift_reg
    logic [ram_addr_bits-1:0] word_ptr;                     // next RAM word to fill
    logic [word_width-1:0]    shift_reg;                    // partial word, lsb first

    logic                     load_start;
    logic [1:0]               byte_idx;
    logic [ram_addr_bits-1:0] word_idx;
    logic                     byte_take;
    logic                     word_done;
    logic [word_width-1:0]    next_word;

    assign load_start = load_mode & ~load_mode_q;             // new load session
    assign byte_idx   = load_start ? 2'd0 : byte_count;       // restart count on rise
    assign word_idx   = load_start ? '0 : word_ptr;           // restart at word 0
    assign byte_take  = load_mode & uart_byte_valid;
    assign word_done  = byte_take & (byte_idx == 2'd3);       // fourth byte of a word
    assign next_word  = {uart_byte, shift_reg[word_width-1:8]}; // new byte enters at top

    always_ff @(posedge clk) begin
        if (reset) begin
            load_mode_q <= 1'b0;
            byte_count  <= 2'd0;
            word_ptr    <= '0;
            load_count  <= '0;
            load_write  <= 1'b0;
        end else begin
            load_mode_q <= load_mode;
            load_write  <= word_done;                           // write one cycle after byte 4
            if (byte_take) begin
                byte_count <= byte_idx + 2'd1;                  // wraps after the fourth byte
            end else begin
                byte_count <= byte_idx;
            end
            if (word_done) begin
                word_ptr <= word_idx + 1'b1;
            end else begin
                word_ptr <= word_idx;
            end
            if (load_start) begin
                load_count <= '0;                               // byte 4 never lands on a rise
            end else if (word_done) begin
                load_count <= load_count + 1'b1;
            end
        end
    end

    // payload only, qualified by byte_count and load_write
    always_ff @(posedge clk) begin
        if (byte_take) begin
            shift_reg <= next_word;
        end
        if (word_done) begin
            load_word      <= next_word;                        // four bytes, lsb first
            load_word_addr <= word_idx;
        end
    end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps

module data_ram #(
    parameter int addr_bits = mem_pkg::ram_addr_bits            // any depth works
) (
    input  logic                           clk,
    input  logic                           enable,              // no access when low
    input  logic                           write_enable,
    input  logic [addr_bits-1:0]           address,             // word address
    input  logic [mem_pkg::word_width-1:0] write_data,
    output logic [mem_pkg::word_width-1:0] read_data            // valid one cycle later
);
    import mem_pkg::*;

    localparam int depth = 1 << addr_bits;

    logic [word_width-1:0] mem [0:depth-1];                    // contents survive reset

    // one port, read-before-write on the same edge
    always_ff @(posedge clk) begin
        if (enable) begin
            if (write_enable) begin
                mem[address] <= write_data;
            end
            read_data <= mem[address];                          // old word on a write
        end
    end

endmodule

// ==== design/mem_access_unit.sv ====
`timescale 1ns/1ps

module mem_access_unit (
    input  logic                               clk,
    input  logic                               reset,
    input  mem_pkg::mem_addr_t                 mem_address,     // byte address from pipeline
    input  logic [mem_pkg::word_width-1:0]     mem_store_data,
    input  logic                               mem_write_enable,
    input  logic                               mem_read_enable,
    input  logic                               no_op,           // bubble, ignore access
    input  logic                               load_mode,       // loader owns the RAM port
    input  logic                               load_write,
    input  logic [mem_pkg::ram_addr_bits-1:0]  load_word_addr,
    input  logic [mem_pkg::word_width-1:0]     load_word,
    input  logic [mem_pkg::word_width-1:0]     keypad_word,     // keypad value this cycle
    output logic [mem_pkg::word_width-1:0]     mem_read_data,   // load result, cycle after
    output logic                               keypad_read,     // keypad access strobe
    output logic                               vga_write        // VGA store strobe
);
    import mem_pkg::*;

    logic                     io_hit;
    logic                     tgt_ram;                          // one-hot target decode
    logic                     tgt_keypad;
    logic                     tgt_vga;
    logic                     pipe_active;                      // pipeline access allowed
    logic                     pipe_read;
    logic                     pipe_write;

    logic                     ram_enable;
    logic                     ram_write;
    logic [ram_addr_bits-1:0] ram_address;
    logic [word_width-1:0]    ram_wdata;
    logic [word_width-1:0]    ram_rdata;

    logic                     rd_valid;                         // a read was issued last cycle
    logic                     rd_ram;                           // ... and it hit the RAM
    logic                     rd_keypad;                        // ... and it hit the keypad
    logic [word_width-1:0]    keypad_hold;                      // keypad word at the read edge
    logic [word_width-1:0]    read_hold;                        // last load result
    logic [word_width-1:0]    read_source;

    // IO view for the window, RAM view for the range check
    assign io_hit      = (mem_address.io.marker == io_marker);
    assign tgt_ram     = (mem_address.ram.upper == '0);
    assign tgt_keypad  = io_hit & ~mem_address.io.dev_type;     // 0xFFFFFC60
    assign tgt_vga     = io_hit &  mem_address.io.dev_type;     // 0xFFFFFC70

    assign pipe_active = ~no_op & ~load_mode;
    assign pipe_read   = pipe_active & mem_read_enable;
    assign pipe_write  = pipe_active & mem_write_enable;

    assign keypad_read = pipe_read  & tgt_keypad;
    assign vga_write   = pipe_write & tgt_vga;                  // never reaches the RAM

    // loader takes the port while load_mode is high
    assign ram_enable  = load_mode ? load_write : ((pipe_read | pipe_write) & tgt_ram);
    assign ram_write   = load_mode ? load_write : (pipe_write & tgt_ram);
    assign ram_address = load_mode ? load_word_addr : mem_address.ram.word_index;
    assign ram_wdata   = load_mode ? load_word : mem_store_data;

    data_ram #(
        .addr_bits    (ram_addr_bits)
    ) i_data_ram (
        .clk          (clk),
        .enable       (ram_enable),
        .write_enable (ram_write),
        .address      (ram_address),
        .write_data   (ram_wdata),
        .read_data    (ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid  <= 1'b0;
            rd_ram    <= 1'b0;
            rd_keypad <= 1'b0;
            read_hold <= '0;
        end else begin
            rd_valid  <= pipe_read;
            rd_ram    <= pipe_read & tgt_ram;
            rd_keypad <= keypad_read;
            read_hold <= mem_read_data;                         // keeps result between reads
        end
    end

    always_ff @(posedge clk) begin
        if (keypad_read) begin
            keypad_hold <= keypad_word;                         // value seen at the read edge
        end
    end

    // unmapped and VGA reads return zero
    assign read_source   = rd_ram    ? ram_rdata   :
                           rd_keypad ? keypad_hold : '0;
    assign mem_read_data = rd_valid ? read_source : read_hold;

endmodule

// ==== design/keypad_port.sv ====
`timescale 1ns/1ps

module keypad_port (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [mem_pkg::word_width-1:0] keypad_data,         // raw keypad value
    input  logic                           keypad_read,         // strobe from access unit
    output logic [mem_pkg::word_width-1:0] keypad_word,         // sampled keypad value
    output logic                           keypad_read_enable   // one-cycle pulse outward
);

    // free-running sample, the access unit picks it at the read edge
    always_ff @(posedge clk) begin
        keypad_word <= keypad_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            keypad_read_enable <= 1'b0;
        end else begin
            keypad_read_enable <= keypad_read;                  // pulse follows the strobe
        end
    end

endmodule

// ==== design/vga_port.sv ====
`timescale 1ns/1ps

module vga_port (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           vga_write,           // store to 0xFFFFFC70
    input  logic [mem_pkg::word_width-1:0] store_data,
    output logic [mem_pkg::word_width-1:0] vga_data,            // word on the display
    output logic                           vga_update           // new word this cycle
);

    always_ff @(posedge clk) begin
        if (reset) begin
            vga_data   <= '0;                                   // blank display
            vga_update <= 1'b0;
        end else begin
            vga_update <= vga_write;                            // single pulse per store
            if (vga_write) begin
                vga_data <= store_data;
            end
        end
    end

endmodule

// ==== design/mem_subsystem_top.sv ====
`timescale 1ns/1ps

module mem_subsystem_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               load_mode,
    input  logic                               uart_byte_valid,
    input  logic [7:0]                         uart_byte,
    input  mem_pkg::mem_addr_t                 mem_address,
    input  logic [mem_pkg::word_width-1:0]     mem_store_data,
    input  logic                               mem_write_enable,
    input  logic                               mem_read_enable,
    input  logic                               no_op,
    input  logic [mem_pkg::word_width-1:0]     keypad_data,
    output logic [mem_pkg::word_width-1:0]     mem_read_data,
    output logic [mem_pkg::ram_addr_bits:0]    load_count,
    output logic                               keypad_read_enable,
    output logic [mem_pkg::word_width-1:0]     vga_data,
    output logic                               vga_update
);
    import mem_pkg::*;

    logic                     load_write;                       // loader to RAM
    logic [ram_addr_bits-1:0] load_word_addr;
    logic [word_width-1:0]    load_word;
    logic [word_width-1:0]    keypad_word;                      // keypad to access unit
    logic                     keypad_read;
    logic                     vga_write;                        // access unit to VGA

    uart_loader i_uart_loader (
        .clk              (clk),
        .reset            (reset),
        .load_mode        (load_mode),
        .uart_byte_valid  (uart_byte_valid),
        .uart_byte        (uart_byte),
        .load_write       (load_write),
        .load_word_addr   (load_word_addr),
        .load_word        (load_word),
        .load_count       (load_count)
    );

    mem_access_unit i_mem_access_unit (
        .clk              (clk),
        .reset            (reset),
        .mem_address      (mem_address),
        .mem_store_data   (mem_store_data),
        .mem_write_enable (mem_write_enable),
        .mem_read_enable  (mem_read_enable),
        .no_op            (no_op),
        .load_mode        (load_mode),
        .load_write       (load_write),
        .load_word_addr   (load_word_addr),
        .load_word        (load_word),
        .keypad_word      (keypad_word),
        .mem_read_data    (mem_read_data),
        .keypad_read      (keypad_read),
        .vga_write        (vga_write)
    );

    keypad_port i_keypad_port (
        .clk                (clk),
        .reset              (reset),
        .keypad_data        (keypad_data),
        .keypad_read        (keypad_read),
        .keypad_word        (keypad_word),
        .keypad_read_enable (keypad_read_enable)
    );

    vga_port i_vga_port (
        .clk              (clk),
        .reset            (reset),
        .vga_write        (vga_write),
        .store_data       (mem_store_data),                     // store data goes straight over
        .vga_data         (vga_data),
        .vga_update       (vga_update)
    );

endmodule

// ==== verif/tb_mem_subsystem.sv ====
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 8;
    // cycle budget of each test, in run order
    localparam int budget_cycles = reset_cycles + 10 + 80 + 50 + 15 + 20 + 35;
    localparam int timeout_ns    = (budget_cycles + 100) * clk_period; // plus margin

    logic                     clk;
    logic                     reset;
    logic                     load_mode;
    logic                     uart_byte_valid;
    logic [7:0]               uart_byte;
    logic [word_width-1:0]    mem_address;                      // plain word, DUT splits it
    logic [word_width-1:0]    mem_store_data;
    logic                     mem_write_enable;
    logic                     mem_read_enable;
    logic                     no_op;
    logic [word_width-1:0]    keypad_data;
    logic [word_width-1:0]    mem_read_data;
    logic [ram_addr_bits:0]   load_count;
    logic                     keypad_read_enable;
    logic [word_width-1:0]    vga_data;
    logic                     vga_update;

    integer                   seed;                             // $random state
    int                       check_count;
    int                       error_count;
    logic [word_width-1:0]    shadow [0:(1<<ram_addr_bits)-1];  // expected RAM contents
    logic [word_width-1:0]    vga_shown;                        // last word sent to the display

    mem_subsystem_top i_mem_subsystem_top (
        .clk                (clk),
        .reset              (reset),
        .load_mode          (load_mode),
        .uart_byte_valid    (uart_byte_valid),
        .uart_byte          (uart_byte),
        .mem_address        (mem_address),
        .mem_store_data     (mem_store_data),
        .mem_write_enable   (mem_write_enable),
        .mem_read_enable    (mem_read_enable),
        .no_op              (no_op),
        .keypad_data        (keypad_data),
        .mem_read_data      (mem_read_data),
        .load_count         (load_count),
        .keypad_read_enable (keypad_read_enable),
        .vga_data           (vga_data),
        .vga_update         (vga_update)
    );

    initial begin
        clk = 1'b0;
    end

    always #(clk_period/2) clk = ~clk;                          // 40 ns period

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("Fail at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: done, no errors", name);
        end else begin
            $display("%s: done, %0d errors", name, error_count - errors_before);
        end
    endtask

    // one store cycle, bubble sets no_op
    task automatic store_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic bubble);
        @(posedge clk);
        mem_address      <= addr;
        mem_store_data   <= data;
        mem_write_enable <= 1'b1;
        no_op            <= bubble;
        @(posedge clk);
        mem_write_enable <= 1'b0;
        no_op            <= 1'b0;
    endtask

    // single load, result checked one cycle after the read edge
    task automatic load_and_check(input logic [31:0] addr, input logic [31:0] expected,
                                  input string name);
        @(posedge clk);
        mem_address     <= addr;
        mem_read_enable <= 1'b1;
        @(posedge clk);
        mem_read_enable <= 1'b0;
        @(negedge clk);
        check_value(name, expected, mem_read_data);
    endtask

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        repeat (6) begin                                        // idle inputs, nothing moves
            @(negedge clk);
            check_value("keypad_read_enable", 32'd0, 32'(keypad_read_enable));
            check_value("vga_update", 32'd0, 32'(vga_update));
            check_value("vga_data", 32'd0, vga_data);
            check_value("mem_read_data", 32'd0, mem_read_data);
            check_value("load_count", 32'd0, 32'(load_count));
        end
        report_test("reset state", errors_before);
    endtask

    task automatic run_uart_load();
        logic [7:0]  bytes [0:31];
        logic [31:0] rnd;
        logic [31:0] word;
        int          errors_before;
        int          wait_cycles;
        errors_before = error_count;
        for (int k = 0; k < 32; k++) begin
            rnd      = $random(seed);
            bytes[k] = rnd[7:0];
        end
        @(posedge clk);
        load_mode <= 1'b1;                                      // loader takes the RAM
        for (int k = 0; k < 32; k++) begin
            @(posedge clk);
            uart_byte_valid <= 1'b1;
            uart_byte       <= bytes[k];
        end
        @(posedge clk);
        uart_byte_valid <= 1'b0;
        wait_cycles = 0;
        do begin                                                // bounded wait for last word
            @(negedge clk);
            wait_cycles++;
        end while (32'(load_count) != 32'd8 && wait_cycles < 10);
        check_value("load_count", 32'd8, 32'(load_count));
        @(posedge clk);
        load_mode <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            word = {bytes[4*i+3], bytes[4*i+2], bytes[4*i+1], bytes[4*i]}; // lsb first
            shadow[i] = word;
            load_and_check(32'(i * 4), word, "mem_read_data");
        end
        report_test("uart load", errors_before);
    endtask

    task automatic ram_store_load();
        logic [ram_addr_bits-1:0] idx [0:5];
        logic [31:0]              rnd;
        logic [31:0]              data;
        int                       errors_before;
        errors_before = error_count;
        for (int i = 0; i < 6; i++) begin
            rnd    = $random(seed);
            idx[i] = rnd[ram_addr_bits+1:2];                    // any word below 0x10000
            data   = $random(seed);
            shadow[idx[i]] = data;
            store_word({{(word_width-ram_addr_bits-2){1'b0}}, idx[i], 2'b00}, data, 1'b0);
        end
        for (int i = 0; i < 6; i++) begin                       // one load per cycle
            @(posedge clk);
            mem_address     <= {{(word_width-ram_addr_bits-2){1'b0}}, idx[i], 2'b00};
            mem_read_enable <= 1'b1;
            @(negedge clk);
            if (i > 0) begin
                check_value("mem_read_data", shadow[idx[i-1]], mem_read_data);
            end
        end
        @(posedge clk);
        mem_read_enable <= 1'b0;
        @(negedge clk);
        check_value("mem_read_data", shadow[idx[5]], mem_read_data);
        // bits 31..16 set, outside the IO window
        load_and_check(32'h0001_0010, 32'd0, "mem_read_data unmapped");
        rnd = $random(seed);
        store_word(32'h0001_0010, rnd, 1'b0);                   // must be dropped
        load_and_check(32'h0000_0010, shadow[4], "mem_read_data after unmapped store");
        report_test("ram store and load", errors_before);
    endtask

    task automatic keypad_read_pulse();
        logic [31:0] kp;
        int          pulse_cycles;
        int          errors_before;
        errors_before = error_count;
        kp = $random(seed);
        @(posedge clk);
        keypad_data <= kp;
        repeat (2) @(posedge clk);                              // keypad sample catches up
        mem_address     <= 32'hFFFF_FC60;
        mem_read_enable <= 1'b1;
        pulse_cycles = 0;
        @(negedge clk);
        if (keypad_read_enable) begin
            pulse_cycles++;
        end
        @(posedge clk);
        mem_read_enable <= 1'b0;
        @(negedge clk);
        if (keypad_read_enable) begin
            pulse_cycles++;
        end
        check_value("mem_read_data", kp, mem_read_data);
        repeat (2) begin
            @(negedge clk);
            if (keypad_read_enable) begin
                pulse_cycles++;
            end
        end
        check_value("keypad_read_enable high cycles", 32'd1, 32'(pulse_cycles));
        check_value("mem_read_data held", kp, mem_read_data);   // holds until next read
        report_test("keypad read", errors_before);
    endtask

    task automatic vga_store_update();
        logic [31:0] under;
        logic [31:0] shown;
        logic [31:0] alias_addr;
        int          errors_before;
        errors_before = error_count;
        alias_addr = 32'h0000_FC70;                             // same low bits as the VGA port
        under      = $random(seed);
        shadow[alias_addr[ram_addr_bits+1:2]] = under;
        store_word(alias_addr, under, 1'b0);
        shown = $random(seed);
        vga_shown = shown;
        @(posedge clk);
        mem_address      <= 32'hFFFF_FC70;
        mem_store_data   <= shown;
        mem_write_enable <= 1'b1;
        @(negedge clk);
        check_value("vga_update", 32'd0, 32'(vga_update));
        @(posedge clk);
        mem_write_enable <= 1'b0;
        @(negedge clk);
        check_value("vga_update", 32'd1, 32'(vga_update));
        check_value("vga_data", shown, vga_data);
        @(negedge clk);
        check_value("vga_update", 32'd0, 32'(vga_update));      // single pulse
        check_value("vga_data", shown, vga_data);
        load_and_check(alias_addr, under, "mem_read_data under VGA address");
        report_test("vga store", errors_before);
    endtask

    task automatic suppressed_stores();
        logic [31:0] rnd;
        logic [31:0] shown;
        int          errors_before;
        errors_before = error_count;
        rnd = $random(seed);
        store_word(32'h0000_0000, rnd, 1'b1);                   // bubble, no RAM write
        load_and_check(32'h0000_0000, shadow[0], "mem_read_data after no_op store");
        @(negedge clk);
        shown = vga_shown;
        rnd   = $random(seed);
        store_word(32'hFFFF_FC70, rnd, 1'b1);                   // bubble, display untouched
        repeat (3) begin
            @(negedge clk);
            check_value("vga_update", 32'd0, 32'(vga_update));
            check_value("vga_data", shown, vga_data);
        end
        @(posedge clk);
        load_mode <= 1'b1;                                      // loader owns the port, no bytes
        rnd = $random(seed);
        store_word(32'h0000_0004, rnd, 1'b0);
        @(posedge clk);
        load_mode <= 1'b0;
        load_and_check(32'h0000_0004, shadow[1], "mem_read_data after load_mode store");
        report_test("no_op and load_mode suppression", errors_before);
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the run went past its cycle budget of %0d ns", timeout_ns);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed        = 32'hba53;
        check_count = 0;
        error_count = 0;
        vga_shown   = 32'd0;
        reset            <= 1'b1;
        load_mode        <= 1'b0;
        uart_byte_valid  <= 1'b0;
        uart_byte        <= 8'd0;
        mem_address      <= 32'd0;
        mem_store_data   <= 32'd0;
        mem_write_enable <= 1'b0;
        mem_read_enable  <= 1'b0;
        no_op            <= 1'b0;
        keypad_data      <= 32'd0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        check_reset_state();
        run_uart_load();
        ram_store_load();
        keypad_read_pulse();
        vga_store_update();
        suppressed_stores();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
design/mem_pkg.sv
design/uart_loader.sv
design/data_ram.sv
design/mem_access_unit.sv
design/keypad_port.sv
design/vga_port.sv
design/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv
